/* common/mic_level_pkg.sv */
// Mic level package with clock setting, I2S frame constants, meter thresholds and stage structs
`default_nettype none

package mic_level_pkg;

    // System clock in MHz, 50 or 100 (100 runs the receiver at half rate)
    localparam int CLK_MHZ = 50;

    // Sample and frame geometry
    localparam int SAMPLE_W    = 24;
    localparam int FRAME_CNT_W = 9;            // 512 enabled cycles per ws half-frame

    // Frame counter decode for the I2S pins
    localparam int SCK_BIT       = 3;          // sck = counter bit 3
    localparam int BIT_STEP      = 2 ** (SCK_BIT + 1);
    localparam int WS_TOGGLE_CNT = 15;
    localparam int FIRST_BIT_CNT = 39;         // One cycle before the second rising sck edge
    localparam int LAST_BIT_CNT  = FIRST_BIT_CNT + (SAMPLE_W - 1) * BIT_STEP;
    localparam int BIT_PHASE     = FIRST_BIT_CNT % BIT_STEP;

    // Level arithmetic
    localparam int DECAY_SHIFT = 4;            // Lose 1/16 per non-rising sample
    localparam logic [SAMPLE_W-1:0] FULL_SCALE = (1 << (SAMPLE_W - 1)) - 1;
    localparam logic [SAMPLE_W-1:0] CLIP_LEVEL = 24'd8323072;  // 2^23 - 2^16

    // Bar graph, segment i lights at 2^(BAR_BASE_BIT + i)
    localparam int BAR_W        = 8;
    localparam int BAR_BASE_BIT = 15;

    // Receiver to follower
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] data;
        logic                       valid;
    } mic_sample_t;

    // Follower to meter
    typedef struct packed {
        logic [SAMPLE_W-1:0] level;
        logic                clip;
        logic                valid;
    } envelope_t;

endpackage

`default_nettype wire

/* i2s_rx/i2s_mic_receiver.sv */
// I2S microphone receiver with sck/ws/lr generation and left-channel word capture
`timescale 1ns/1ps
`default_nettype none

module i2s_mic_receiver
(
    input  logic                      clk,
    input  logic                      rst,
    output logic                      sck,
    output logic                      ws,
    output logic                      lr,
    input  logic                      sd,
    output mic_level_pkg::mic_sample_t sample
);

    import mic_level_pkg::*;

    logic                   clk_en;
    logic [FRAME_CNT_W-1:0] cnt;
    logic [SAMPLE_W-1:0]    shift;
    logic                   left_half;
    logic                   sample_bit;
    logic                   word_done;

    // Mic select pin low puts the mic on the left channel
    assign lr = 1'b0;

    generate
        if (CLK_MHZ == 100)
        begin : gen_half_rate
            always_ff @(posedge clk or posedge rst)
            begin
                if (rst)
                    clk_en <= 1'b0;
                else
                    clk_en <= ~clk_en;
            end
        end
        else
        begin : gen_full_rate
            assign clk_en = 1'b1;
        end
    endgenerate

    // Free-running frame counter
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (clk_en)
            cnt <= cnt + 1'b1;
    end

    assign sck = cnt[SCK_BIT];                 // clk/16 at 50 MHz

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ws <= 1'b1;
        else if (clk_en && cnt == FRAME_CNT_W'(WS_TOGGLE_CNT))
            ws <= ~ws;
    end

    assign left_half = (ws == lr);

    // Sample sd just before each rising sck edge of the 24 data bits
    assign sample_bit = left_half
                     && cnt >= FRAME_CNT_W'(FIRST_BIT_CNT)
                     && cnt <= FRAME_CNT_W'(LAST_BIT_CNT)
                     && cnt[SCK_BIT:0] == (SCK_BIT + 1)'(BIT_PHASE);

    assign word_done = left_half && (cnt == '1);

    // MSB first
    always_ff @(posedge clk)
    begin
        if (clk_en && sample_bit)
            shift <= {shift[SAMPLE_W-2:0], sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample <= '0;
        end
        else
        begin
            sample.valid <= clk_en && word_done;  // One clk cycle even at half rate
            if (clk_en && word_done)
                sample.data <= shift;
        end
    end

endmodule

`default_nettype wire

/* logic/envelope_follower.sv */
// Envelope follower with saturating magnitude, clip detect and peak attack/decay
`timescale 1ns/1ps
`default_nettype none

module envelope_follower
(
    input  logic                       clk,
    input  logic                       rst,
    input  mic_level_pkg::mic_sample_t sample,
    output mic_level_pkg::envelope_t   envelope
);

    import mic_level_pkg::*;

    logic [SAMPLE_W-1:0] neg_data;
    logic [SAMPLE_W-1:0] magnitude;
    logic [SAMPLE_W-1:0] decayed;
    logic [SAMPLE_W-1:0] level_next;
    logic                rising;

    // Absolute value, two's complement negate for negative samples
    assign neg_data = SAMPLE_W'(0) - sample.data;

    always_comb
    begin
        if (!sample.data[SAMPLE_W-1])
            magnitude = sample.data;
        else if (neg_data[SAMPLE_W-1])
            magnitude = FULL_SCALE;            // -2^23 has no positive twin
        else
            magnitude = neg_data;
    end

    // Decay by a fixed fraction of the current envelope
    assign decayed = envelope.level - (envelope.level >> DECAY_SHIFT);

    assign rising = magnitude > envelope.level;

    always_comb
    begin
        if (rising)
            level_next = magnitude;            // Instant attack
        else
            level_next = decayed;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            envelope <= '0;
        end
        else
        begin
            envelope.valid <= sample.valid;
            if (sample.valid)
            begin
                envelope.level <= level_next;
                envelope.clip  <= magnitude >= CLIP_LEVEL;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/level_meter.sv */
// Level meter with thermometer bar graph and registered level, bar and clip display
`timescale 1ns/1ps
`default_nettype none

module level_meter
(
    input  logic                                clk,
    input  logic                                rst,
    input  mic_level_pkg::envelope_t            envelope,
    output logic [mic_level_pkg::SAMPLE_W-1:0]  level,
    output logic [mic_level_pkg::BAR_W-1:0]     bar,
    output logic                                clip,
    output logic                                out_valid
);

    import mic_level_pkg::*;

    logic [BAR_W-1:0] bar_next;

    // One power-of-two threshold per segment gives a thermometer code
    always_comb
    begin
        for (int i = 0; i < BAR_W; i++)
        begin
            bar_next[i] = envelope.level >= (SAMPLE_W'(1) << (BAR_BASE_BIT + i));
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            level     <= '0;
            bar       <= '0;
            clip      <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= envelope.valid;
            if (envelope.valid)                // Display holds between samples
            begin
                level <= envelope.level;
                bar   <= bar_next;
                clip  <= envelope.clip;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mic_level_top.sv */
// Mic level top connecting the I2S receiver, envelope follower and level meter
`timescale 1ns/1ps
`default_nettype none

module mic_level_top
(
    input  logic                                clk,
    input  logic                                rst,
    output logic                                sck,
    output logic                                ws,
    output logic                                lr,
    input  logic                                sd,
    output logic [mic_level_pkg::SAMPLE_W-1:0]  level,
    output logic [mic_level_pkg::BAR_W-1:0]     bar,
    output logic                                clip,
    output logic                                out_valid
);

    import mic_level_pkg::*;

    mic_sample_t sample;     // Decoded left-channel word
    envelope_t   envelope;   // Peak level with clip

    i2s_mic_receiver u_receiver
    (
        .clk    (clk),
        .rst    (rst),
        .sck    (sck),
        .ws     (ws),
        .lr     (lr),
        .sd     (sd),
        .sample (sample)
    );

    envelope_follower u_follower
    (
        .clk      (clk),
        .rst      (rst),
        .sample   (sample),
        .envelope (envelope)
    );

    level_meter u_meter
    (
        .clk       (clk),
        .rst       (rst),
        .envelope  (envelope),
        .level     (level),
        .bar       (bar),
        .clip      (clip),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

/* tests/tb_mic_level.sv */
// Testbench for the mic level path with clock, reset, trace-driven I2S mic model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_mic_level;

    import mic_level_pkg::*;

    localparam int NUM_SAMPLES   = 48;
    localparam int TRACE_COLS    = 4;          // Sample, level, bar, clip
    localparam int FRAME_CYCLES  = 1024;       // One sample per frame at 50 MHz
    localparam int VALID_TIMEOUT = 3000;
    localparam int RESET_CYCLES  = 16;
    localparam int DRIVE_DELAY   = 1;

    logic                clk;
    logic                rst;
    logic                sck;
    logic                ws;
    logic                lr;
    logic                sd = 1'b0;
    logic [SAMPLE_W-1:0] level;
    logic [BAR_W-1:0]    bar;
    logic                clip;
    logic                out_valid;

    // Flat copy of the trace, TRACE_COLS words per sample
    logic [SAMPLE_W-1:0] trace_mem [0:NUM_SAMPLES*TRACE_COLS-1];

    int error_count   = 0;
    int timeout_count = 0;
    int samples_done  = 0;
    int cycle_count   = 0;

    // Mic model state
    logic                ws_prev   = 1'b1;
    logic                sck_prev  = 1'b0;
    logic [SAMPLE_W-1:0] tx_word   = '0;
    int                  tx_index  = 0;
    int                  sck_falls = 0;

    mic_level_top u_dut
    (
        .clk       (clk),
        .rst       (rst),
        .sck       (sck),
        .ws        (ws),
        .lr        (lr),
        .sd        (sd),
        .level     (level),
        .bar       (bar),
        .clip      (clip),
        .out_valid (out_valid)
    );

    always #4 clk = ~clk;                      // 8 ns period

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    // I2S mic model, one trace word per left half-frame, MSB first
    always @(posedge clk)
    begin
        #(DRIVE_DELAY);
        if (ws_prev && !ws)
        begin
            tx_word   = (tx_index < NUM_SAMPLES) ? trace_mem[tx_index*TRACE_COLS] : '0;
            tx_index  = tx_index + 1;
            sck_falls = 1;                     // First sck fall comes with the ws fall
            sd        = 1'b0;
        end
        else if (ws)
        begin
            sd = 1'b0;                         // Right half stays quiet
        end
        else if (sck_prev && !sck)
        begin
            sck_falls = sck_falls + 1;
            // Data starts one sck period after ws
            if (sck_falls >= 2 && sck_falls <= SAMPLE_W + 1)
                sd = tx_word[SAMPLE_W + 1 - sck_falls];
            else
                sd = 1'b0;
        end
        ws_prev  = ws;
        sck_prev = sck;
    end

    // Counts a mismatch and prints it with the time and both values
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] got);
        error_count++;
        $display("[ERROR] %0d ns: %s expected %0h got %0h", $time, name, expected, got);
    endtask

    // Steps on falling edges until out_valid is high or the timeout runs out
    task automatic wait_for_out_valid(output bit seen);
        int waited;

        waited = 0;
        @(negedge clk);
        while (out_valid !== 1'b1 && waited < VALID_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        seen = (out_valid === 1'b1);
    endtask

    initial
    begin
        bit                  got_valid;
        int                  last_cycle;
        int                  period;
        logic [SAMPLE_W-1:0] exp_level;
        logic [BAR_W-1:0]    exp_bar;
        logic                exp_clip;

        clk = 1'b0;
        rst = 1'b1;
        $readmemh("tests/mic_level_trace.txt", trace_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;

        // Idle outputs, long before the first ws fall
        @(negedge clk);
        if (out_valid !== 1'b0)
            report_mismatch("out_valid", 32'(0), 32'(out_valid));
        if (level !== '0)
            report_mismatch("level", 32'(0), 32'(level));
        if (bar !== '0)
            report_mismatch("bar", 32'(0), 32'(bar));
        if (clip !== 1'b0)
            report_mismatch("clip", 32'(0), 32'(clip));
        if (sck !== 1'b0)
            report_mismatch("sck", 32'(0), 32'(sck));
        if (ws !== 1'b1)
            report_mismatch("ws", 32'(1), 32'(ws));
        if (lr !== 1'b0)
            report_mismatch("lr", 32'(0), 32'(lr));

        last_cycle = 0;
        got_valid  = 1'b1;
        for (int n = 0; n < NUM_SAMPLES && got_valid; n++)
        begin
            wait_for_out_valid(got_valid);
            if (!got_valid)
            begin
                timeout_count++;
                $display("Timeout waiting for out_valid of sample %0d after %0d cycles",
                         n, VALID_TIMEOUT);
            end
            else
            begin
                exp_level = trace_mem[n*TRACE_COLS + 1];
                exp_bar   = BAR_W'(trace_mem[n*TRACE_COLS + 2]);
                exp_clip  = trace_mem[n*TRACE_COLS + 3][0];
                period    = cycle_count - last_cycle;

                if (level !== exp_level)
                    report_mismatch("level", 32'(exp_level), 32'(level));
                if (bar !== exp_bar)
                    report_mismatch("bar", 32'(exp_bar), 32'(bar));
                if (clip !== exp_clip)
                    report_mismatch("clip", 32'(exp_clip), 32'(clip));
                if (n > 0 && period != FRAME_CYCLES)
                    report_mismatch("out_valid period", 32'(FRAME_CYCLES), 32'(period));
                if (ws !== 1'b0)               // Still in the left half-frame
                    report_mismatch("ws", 32'(0), 32'(ws));
                if (lr !== 1'b0)
                    report_mismatch("lr", 32'(0), 32'(lr));
                last_cycle = cycle_count;

                // Strobe lasts one cycle
                @(negedge clk);
                if (out_valid !== 1'b0)
                    report_mismatch("out_valid", 32'(0), 32'(out_valid));
                samples_done++;
            end
        end

        $display("Samples %0d of %0d, errors %0d, timeouts %0d",
                 samples_done, NUM_SAMPLES, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && samples_done == NUM_SAMPLES)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/mic_level_trace.txt */
// Columns are sample word, expected level, expected bar and expected clip, all in hex
// One line per left-channel sample, in the order the mic sends them
000000 000000 00 0
FFFFFF 000001 00 0
000020 000020 00 0
000000 00001E 00 0
000000 00001D 00 0
000000 00001C 00 0
FFFFF0 00001B 00 0
FFFFE0 000020 00 0
008800 008800 01 0
000000 007F80 00 0
000005 007788 00 0
FFFFFB 007010 00 0
000000 00690F 00 0
000000 00627F 00 0
007FFF 007FFF 00 0
FF8000 008000 01 0
00FFFF 00FFFF 01 0
FF0000 010000 03 0
020000 020000 07 0
FC0000 040000 0F 0
07FFFF 07FFFF 0F 0
080000 080000 1F 0
F00000 100000 3F 0
200000 200000 7F 0
C00001 3FFFFF 7F 0
C00000 400000 FF 0
3FFFFF 3C0000 7F 0
7F0000 7F0000 FF 1
7EFFFF 771000 FF 0
800000 7FFFFF FF 1
000000 780000 FF 0
7FFFFF 7FFFFF FF 1
FF0000 780000 FF 0
810000 7F0000 FF 1
810001 771000 FF 0
000100 6F9F00 FF 0
000000 68A510 FF 0
FFFF00 621ABF FF 0
000000 5BF914 FF 0
000010 563983 FF 0
000000 50D5EB FF 0
FFFFFF 4BC88D FF 0
000000 470C05 FF 0
000000 429B45 FF 0
000000 3E7191 7F 0
FFF000 3A8A78 7F 0
400000 400000 FF 0
000000 3C0000 7F 0

/* mic_level.f */
common/mic_level_pkg.sv
i2s_rx/i2s_mic_receiver.sv
logic/envelope_follower.sv
logic/level_meter.sv
logic/mic_level_top.sv
tests/tb_mic_level.sv

/* Makefile */
# Verilator simulation of the mic level testbench

TOP := tb_mic_level

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f mic_level.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
